//--- hdl/trace_pkg.sv
// trace widths, window and trap constants, record types, interrupter window check
`default_nettype none

package trace_pkg;

  localparam int xlen           = 64;
  localparam int inst_width     = 32;
  localparam int reg_addr_width = 5;
  localparam int wdest_width    = 8;
  localparam int mask_width     = 8;

  // address bits 63:16 of the core-local interrupter window
  localparam logic [xlen-17:0] mmio_window_base = 48'h0000_0000_0200;

  // custom opcode that ends a run
  localparam logic [6:0] trap_opcode = 7'h6b;

  typedef logic [xlen-1:0]       xlen_t;
  typedef logic [inst_width-1:0] inst_t;

  typedef struct packed {
    xlen_t                 addr;
    xlen_t                 data;
    logic [mask_width-1:0] mask;
  } store_rec_t;

  // one writeback record as seen by the commit trace
  typedef struct packed {
    xlen_t                  pc;
    inst_t                  inst;
    logic                   wen;
    logic [wdest_width-1:0] wdest;
    xlen_t                  wdata;
    logic                   skip;
    inst_t                  intr_no;
    inst_t                  excp_no;
  } commit_rec_t;

  // true for any address inside the interrupter window
  function automatic logic in_mmio_window(input xlen_t addr);
    return addr[xlen-1:16] == mmio_window_base;
  endfunction

endpackage

`default_nettype wire

//--- hdl/commit_delay.sv
// valid-tagged delay line with a configurable payload type and depth
`default_nettype none

module commit_delay #(
  parameter type payload_t = logic,
  parameter int  depth     = 1
) (
  input  wire logic     clock,
  input  wire logic     reset,
  input  wire logic     in_valid,
  input  wire payload_t in_data,
  output logic          out_valid,
  output payload_t      out_data
);

  logic [depth-1:0] valid_q;
  payload_t         data_q [depth];

  always_ff @(posedge clock) begin
    if (reset) begin
      valid_q <= '0;
    end else begin
      valid_q[0] <= in_valid;
      for (int i = 1; i < depth; i++) begin
        valid_q[i] <= valid_q[i-1];
      end
    end
  end

  // payload shifts every cycle, valid bit tells which stages hold a real item
  always_ff @(posedge clock) begin
    data_q[0] <= in_data;
    for (int i = 1; i < depth; i++) begin
      data_q[i] <= data_q[i-1];
    end
  end

  assign out_valid = valid_q[depth-1];
  assign out_data  = data_q[depth-1];

endmodule

`default_nettype wire

//--- hdl/commit_register.sv
// commit record register with commit, arch event and trap outputs
`default_nettype none

module commit_register (
  input  wire logic                                  clock,
  input  wire logic                                  reset,
  input  wire logic                                  wb_commit,
  input  wire trace_pkg::xlen_t                      wb_pc,
  input  wire trace_pkg::inst_t                      wb_inst,
  input  wire logic                                  wb_skip,
  input  wire trace_pkg::inst_t                      wb_itrp_no,
  input  wire trace_pkg::inst_t                      wb_excp_no,
  input  wire logic                                  wb_mie,
  input  wire logic                                  reg_wr_ena,
  input  wire logic [trace_pkg::reg_addr_width-1:0]  reg_wr_addr,
  input  wire trace_pkg::xlen_t                      reg_wr_data,
  input  wire trace_pkg::xlen_t                      wb_rw_addr,
  input  wire trace_pkg::xlen_t                      a0_value,
  output logic                                       commit_valid,
  output trace_pkg::xlen_t                           commit_pc,
  output trace_pkg::inst_t                           commit_inst,
  output logic                                       commit_skip,
  output logic                                       commit_wen,
  output logic [trace_pkg::wdest_width-1:0]          commit_wdest,
  output trace_pkg::xlen_t                           commit_wdata,
  output trace_pkg::inst_t                           intr_no,
  output trace_pkg::inst_t                           cause,
  output logic                                       trap_valid,
  output logic [7:0]                                 trap_code
);

  import trace_pkg::*;

  logic        rec_valid;
  commit_rec_t rec_in;
  logic        cmt_valid;
  commit_rec_t cmt_rec;

  // a pending interrupt takes the slot, so nothing commits
  assign rec_valid = wb_commit & ~(|wb_itrp_no);

  always_comb begin
    rec_in.pc      = wb_pc;
    rec_in.inst    = wb_inst;
    rec_in.wen     = reg_wr_ena;
    rec_in.wdest   = {{(wdest_width - reg_addr_width){1'b0}}, reg_wr_addr};
    rec_in.wdata   = reg_wr_data;
    // interrupter registers have no golden model, skip compare
    rec_in.skip    = wb_skip | in_mmio_window(wb_rw_addr);
    // masked with this cycle's enable
    rec_in.intr_no = {inst_width{wb_mie}} & wb_itrp_no;
    rec_in.excp_no = wb_excp_no;
  end

  commit_delay #(
    .payload_t (commit_rec_t),
    .depth     (1)
  ) u_commit_delay (
    .clock     (clock),
    .reset     (reset),
    .in_valid  (rec_valid),
    .in_data   (rec_in),
    .out_valid (cmt_valid),
    .out_data  (cmt_rec)
  );

  // an excepting instruction does not commit
  assign commit_valid = cmt_valid & ~(|cmt_rec.excp_no);
  assign commit_pc    = cmt_rec.pc;
  assign commit_inst  = cmt_rec.inst;
  assign commit_skip  = cmt_rec.skip;
  assign commit_wen   = cmt_rec.wen;
  assign commit_wdest = cmt_rec.wdest;
  assign commit_wdata = cmt_rec.wdata;

  // arch event
  assign intr_no = cmt_rec.intr_no;
  assign cause   = cmt_rec.excp_no & {inst_width{cmt_valid}};

  // trap, exit code taken from a0
  assign trap_valid = cmt_valid & (cmt_rec.inst[6:0] == trap_opcode);
  assign trap_code  = a0_value[7:0];

endmodule

`default_nettype wire

//--- hdl/event_counters.sv
// cycle and committed-instruction counters
`default_nettype none

module event_counters (
  input  wire logic       clock,
  input  wire logic       reset,
  input  wire logic       wb_commit,
  output trace_pkg::xlen_t cycle_count,
  output trace_pkg::xlen_t instr_count
);

  import trace_pkg::*;

  always_ff @(posedge clock) begin
    if (reset) begin
      cycle_count <= '0;
      instr_count <= '0;
    end else begin
      cycle_count <= cycle_count + xlen_t'(1);
      // counts every writeback commit, interrupts included
      instr_count <= instr_count + xlen_t'(wb_commit);
    end
  end

endmodule

`default_nettype wire

//--- hdl/store_tracker.sv
// two-cycle store event delay with interrupter window filter
`default_nettype none

module store_tracker (
  input  wire logic                             clock,
  input  wire logic                             reset,
  input  wire logic                             wb_commit,
  input  wire logic                             wb_w_ena,
  input  wire logic                             wb_r_ena,
  input  wire trace_pkg::xlen_t                 wb_rw_addr,
  input  wire trace_pkg::xlen_t                 wb_w_data,
  input  wire logic [trace_pkg::mask_width-1:0] wb_w_mask,
  output logic                                  store_valid,
  output trace_pkg::xlen_t                      store_addr,
  output trace_pkg::xlen_t                      store_data,
  output logic [trace_pkg::mask_width-1:0]      store_mask
);

  import trace_pkg::*;

  logic       store_in;
  store_rec_t rec_in;
  logic       dly_valid;
  store_rec_t dly_rec;

  // only committed writes enter the store line, loads never do
  assign store_in = wb_commit & wb_w_ena;

  assign rec_in.addr = wb_rw_addr;
  assign rec_in.data = wb_w_data;
  assign rec_in.mask = wb_w_mask;

  commit_delay #(
    .payload_t (store_rec_t),
    .depth     (2)
  ) u_store_delay (
    .clock     (clock),
    .reset     (reset),
    .in_valid  (store_in),
    .in_data   (rec_in),
    .out_valid (dly_valid),
    .out_data  (dly_rec)
  );

  // filter on the store's own address
  assign store_valid = dly_valid & ~in_mmio_window(dly_rec.addr);
  assign store_addr  = dly_rec.addr;
  assign store_data  = dly_rec.data;
  assign store_mask  = dly_rec.mask;

endmodule

`default_nettype wire

//--- hdl/commit_tracer.sv
// commit tracer top level with commit register, event counters and store tracker
`default_nettype none

module commit_tracer (
  input  wire logic                                 clock,
  input  wire logic                                 reset,
  input  wire logic                                 wb_commit,
  input  wire trace_pkg::xlen_t                     wb_pc,
  input  wire trace_pkg::inst_t                     wb_inst,
  input  wire logic                                 wb_skip,
  input  wire trace_pkg::inst_t                     wb_itrp_no,
  input  wire trace_pkg::inst_t                     wb_excp_no,
  input  wire logic                                 wb_mie,
  input  wire logic                                 reg_wr_ena,
  input  wire logic [trace_pkg::reg_addr_width-1:0] reg_wr_addr,
  input  wire trace_pkg::xlen_t                     reg_wr_data,
  input  wire trace_pkg::xlen_t                     wb_rw_addr,
  input  wire trace_pkg::xlen_t                     wb_w_data,
  input  wire logic [trace_pkg::mask_width-1:0]     wb_w_mask,
  input  wire logic                                 wb_w_ena,
  input  wire logic                                 wb_r_ena,
  input  wire trace_pkg::xlen_t                     a0_value,
  output logic                                      commit_valid,
  output trace_pkg::xlen_t                          commit_pc,
  output trace_pkg::inst_t                          commit_inst,
  output logic                                      commit_skip,
  output logic                                      commit_wen,
  output logic [trace_pkg::wdest_width-1:0]         commit_wdest,
  output trace_pkg::xlen_t                          commit_wdata,
  output trace_pkg::inst_t                          intr_no,
  output trace_pkg::inst_t                          cause,
  output logic                                      trap_valid,
  output logic [7:0]                                trap_code,
  output trace_pkg::xlen_t                          cycle_count,
  output trace_pkg::xlen_t                          instr_count,
  output logic                                      store_valid,
  output trace_pkg::xlen_t                          store_addr,
  output trace_pkg::xlen_t                          store_data,
  output logic [trace_pkg::mask_width-1:0]          store_mask
);

  // instruction commit, arch event and trap
  commit_register u_commit_register (
    .clock        (clock),
    .reset        (reset),
    .wb_commit    (wb_commit),
    .wb_pc        (wb_pc),
    .wb_inst      (wb_inst),
    .wb_skip      (wb_skip),
    .wb_itrp_no   (wb_itrp_no),
    .wb_excp_no   (wb_excp_no),
    .wb_mie       (wb_mie),
    .reg_wr_ena   (reg_wr_ena),
    .reg_wr_addr  (reg_wr_addr),
    .reg_wr_data  (reg_wr_data),
    .wb_rw_addr   (wb_rw_addr),
    .a0_value     (a0_value),
    .commit_valid (commit_valid),
    .commit_pc    (commit_pc),
    .commit_inst  (commit_inst),
    .commit_skip  (commit_skip),
    .commit_wen   (commit_wen),
    .commit_wdest (commit_wdest),
    .commit_wdata (commit_wdata),
    .intr_no      (intr_no),
    .cause        (cause),
    .trap_valid   (trap_valid),
    .trap_code    (trap_code)
  );

  event_counters u_event_counters (
    .clock       (clock),
    .reset       (reset),
    .wb_commit   (wb_commit),
    .cycle_count (cycle_count),
    .instr_count (instr_count)
  );

  // store events, two cycles behind writeback
  store_tracker u_store_tracker (
    .clock       (clock),
    .reset       (reset),
    .wb_commit   (wb_commit),
    .wb_w_ena    (wb_w_ena),
    .wb_r_ena    (wb_r_ena),
    .wb_rw_addr  (wb_rw_addr),
    .wb_w_data   (wb_w_data),
    .wb_w_mask   (wb_w_mask),
    .store_valid (store_valid),
    .store_addr  (store_addr),
    .store_data  (store_data),
    .store_mask  (store_mask)
  );

endmodule

`default_nettype wire

//--- tests/commit_tracer_assertions.sv
// concurrent checks on commit tracer outputs, bound to the top level
`default_nettype none

module commit_tracer_assertions (
  input wire logic             clock,
  input wire logic             reset,
  input wire logic             commit_valid,
  input wire trace_pkg::inst_t intr_no,
  input wire trace_pkg::inst_t cause,
  input wire logic             store_valid,
  input wire trace_pkg::xlen_t store_addr,
  input wire trace_pkg::xlen_t cycle_count,
  input wire trace_pkg::xlen_t instr_count
);

  int failures = 0;

  // stores into the interrupter window never show up
  store_outside_window: assert property (
    @(posedge clock) disable iff (reset) store_valid |-> store_addr[63:16] != 48'h0200
  ) else begin
    failures++;
    $error("store reported inside the interrupter window");
  end

  // a committed instruction carries no arch event
  commit_without_event: assert property (
    @(posedge clock) disable iff (reset) commit_valid |-> intr_no == '0 && cause == '0
  ) else begin
    failures++;
    $error("commit reported together with an interrupt or exception");
  end

  instr_within_cycles: assert property (
    @(posedge clock) disable iff (reset) instr_count <= cycle_count
  ) else begin
    failures++;
    $error("instruction count ran ahead of cycle count");
  end

endmodule

`default_nettype wire

//--- tests/commit_tracer_tb.sv
// commit tracer testbench with stimulus table, rule-based expected values and watchdog
`default_nettype none

module commit_tracer_tb;

  localparam int active_rows = 33;
  localparam int num_rows    = active_rows + 2;

  // writeback stimulus of one cycle, then what must be seen just before it is applied
  typedef struct packed {
    logic        commit;
    logic [63:0] pc;
    logic [31:0] inst;
    logic        skip;
    logic [31:0] itrp;
    logic [31:0] excp;
    logic        mie;
    logic        wen;
    logic [4:0]  waddr;
    logic [63:0] wdata;
    logic [63:0] rw_addr;
    logic [63:0] w_data;
    logic [7:0]  mask;
    logic        w_ena;
    logic        r_ena;
    logic [63:0] a0;
    logic        x_commit;
    logic        x_skip;
    logic [31:0] x_intr;
    logic [31:0] x_cause;
    logic        x_trap;
    logic        x_store;
    logic [63:0] x_instr;
  } row_t;

  row_t        rows [num_rows];
  row_t        cur;
  logic        clock;
  logic        reset;
  int          seed;
  int          errors;
  int          checks;
  logic        commit_valid;
  logic [63:0] commit_pc;
  logic [31:0] commit_inst;
  logic        commit_skip;
  logic        commit_wen;
  logic [7:0]  commit_wdest;
  logic [63:0] commit_wdata;
  logic [31:0] intr_no;
  logic [31:0] cause;
  logic        trap_valid;
  logic [7:0]  trap_code;
  logic [63:0] cycle_count;
  logic [63:0] instr_count;
  logic        store_valid;
  logic [63:0] store_addr;
  logic [63:0] store_data;
  logic [7:0]  store_mask;

  commit_tracer dut (
    .wb_commit   (cur.commit),
    .wb_pc       (cur.pc),
    .wb_inst     (cur.inst),
    .wb_skip     (cur.skip),
    .wb_itrp_no  (cur.itrp),
    .wb_excp_no  (cur.excp),
    .wb_mie      (cur.mie),
    .reg_wr_ena  (cur.wen),
    .reg_wr_addr (cur.waddr),
    .reg_wr_data (cur.wdata),
    .wb_rw_addr  (cur.rw_addr),
    .wb_w_data   (cur.w_data),
    .wb_w_mask   (cur.mask),
    .wb_w_ena    (cur.w_ena),
    .wb_r_ena    (cur.r_ena),
    .a0_value    (cur.a0),
    .*
  );

  bind commit_tracer commit_tracer_assertions u_assertions (.*);

  initial begin
    clock = 1'b0;
    forever #2 clock = ~clock;
  end

  // table length plus reset plus margin, four time units per cycle
  initial begin
    #((num_rows + 24) * 4);
    $display("timeout: run did not finish within %0d cycles", num_rows + 24);
    $display("sim failed");
    $finish;
  end

  // core-local interrupter range 0x0200_0000 .. 0x0200_ffff
  function automatic logic inside_window(input logic [63:0] addr);
    return addr >= 64'h0000_0000_0200_0000 && addr <= 64'h0000_0000_0200_ffff;
  endfunction

  task automatic check_value(input string what, input logic [63:0] got,
                             input logic [63:0] exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("FAIL %0t: %s is %0h, expected %0h", $time, what, got, exp);
    end
  endtask

  task automatic build_table();
    row_t        r;
    row_t        p;
    row_t        q;
    logic [63:0] committed;
    committed = '0;
    for (int i = 0; i < num_rows; i++) begin
      r = '0;
      if (i < active_rows) begin
        r.commit  = 1'b1;
        r.pc      = 64'h8000_0000 + 64'(i) * 64'd4;
        r.inst    = $random(seed);
        r.inst[6:0] = 7'h33;
        r.wen     = (i % 3) != 0;
        r.waddr   = 5'(i);
        r.wdata   = {$random(seed), $random(seed)};
        r.rw_addr = {32'h0, $random(seed)};
        r.w_data  = {$random(seed), $random(seed)};
        r.mask    = 8'($random(seed));
        r.a0      = {$random(seed), $random(seed)};
        case (i % 8)
          1: r.w_ena = 1'b1;
          2: r.r_ena = 1'b1;
          3: begin
            r.itrp = 32'd7;
            r.mie  = i[3];
          end
          4: r.excp = 32'd2;
          5: begin
            r.w_ena   = 1'b1;
            r.rw_addr = 64'h0000_0000_0200_bff8;
          end
          6: r.skip = 1'b1;
          // no commit, so neither the exception nor the trap opcode may show
          7: begin
            r.commit    = 1'b0;
            r.w_ena     = 1'b1;
            r.excp      = 32'd5;
            r.inst[6:0] = 7'h6b;
          end
          default: ;
        endcase
        if (i == active_rows - 1) begin
          r.inst[6:0] = 7'h6b;
        end
      end
      // commit rules look one row back, stores two rows back
      p = (i >= 1) ? rows[i-1] : '0;
      q = (i >= 2) ? rows[i-2] : '0;
      r.x_commit = p.commit && p.itrp == 0 && p.excp == 0;
      r.x_skip   = p.skip || inside_window(p.rw_addr);
      r.x_intr   = p.mie ? p.itrp : 32'd0;
      r.x_cause  = (p.commit && p.itrp == 0) ? p.excp : 32'd0;
      r.x_trap   = p.commit && p.itrp == 0 && p.inst[6:0] == 7'h6b;
      r.x_store  = q.commit && q.w_ena && !inside_window(q.rw_addr);
      r.x_instr  = committed;
      committed  = committed + 64'(r.commit);
      rows[i]    = r;
    end
  endtask

  task automatic check_row(input int k);
    row_t p;
    row_t q;
    p = (k >= 1) ? rows[k-1] : '0;
    q = (k >= 2) ? rows[k-2] : '0;
    check_value("commit_valid", 64'(commit_valid), 64'(rows[k].x_commit));
    if (rows[k].x_commit) begin
      check_value("commit_pc", commit_pc, p.pc);
      check_value("commit_inst", 64'(commit_inst), 64'(p.inst));
      check_value("commit_wen", 64'(commit_wen), 64'(p.wen));
      check_value("commit_wdest", 64'(commit_wdest), 64'(p.waddr));
      check_value("commit_wdata", commit_wdata, p.wdata);
      check_value("commit_skip", 64'(commit_skip), 64'(rows[k].x_skip));
    end
    check_value("intr_no", 64'(intr_no), 64'(rows[k].x_intr));
    check_value("cause", 64'(cause), 64'(rows[k].x_cause));
    check_value("trap_valid", 64'(trap_valid), 64'(rows[k].x_trap));
    if (rows[k].x_trap) begin
      check_value("trap_code", 64'(trap_code), 64'(p.a0[7:0]));
    end
    check_value("store_valid", 64'(store_valid), 64'(rows[k].x_store));
    if (rows[k].x_store) begin
      check_value("store_addr", store_addr, q.rw_addr);
      check_value("store_data", store_data, q.w_data);
      check_value("store_mask", 64'(store_mask), 64'(q.mask));
    end
    check_value("cycle_count", cycle_count, 64'(k));
    check_value("instr_count", instr_count, rows[k].x_instr);
  endtask

  initial begin
    seed   = 32;
    errors = 0;
    checks = 0;
    cur    = '0;
    reset  = 1'b1;
    build_table();
    repeat (4) @(posedge clock);
    @(negedge clock);
    reset = 1'b0;
    // check what the last edge produced, then drive the next row
    for (int k = 0; k < num_rows; k++) begin
      if (k > 0) begin
        @(negedge clock);
      end
      check_row(k);
      cur = rows[k];
    end
    $display("%0d checks, %0d value errors, %0d assertion failures",
             checks, errors, dut.u_assertions.failures);
    if (errors == 0 && dut.u_assertions.failures == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- all.f
hdl/trace_pkg.sv
hdl/commit_delay.sv
hdl/commit_register.sv
hdl/event_counters.sv
hdl/store_tracker.sv
hdl/commit_tracer.sv
tests/commit_tracer_assertions.sv
tests/commit_tracer_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the commit tracer testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f all.f --top-module commit_tracer_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

output=$(./obj_dir/Vcommit_tracer_tb +verilator+error+limit+100)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$output" | grep -qx "sim passed"; then
  exit 0
fi
exit 1
